//--- rtl/pattern_pkg.sv
// Register map, response codes and default sizes for the pattern streamer
// Register indices are word indices, not byte addresses
// Any change to the register map should bump MODULE_VERSION

`default_nettype none

package pattern_pkg;

   // ========================================================
   // Widths and defaults
   // ========================================================
   localparam int REG_DATA_WIDTH        = 32;
   localparam int REG_INDEX_WIDTH       = 5;
   localparam int DEFAULT_PATTERN_WIDTH = 32;
   localparam int DEFAULT_FIFO_DEPTH    = 16;

   // Revision reported by REG_MODULE_REV
   localparam logic [REG_DATA_WIDTH-1:0] MODULE_VERSION = 32'd1;

   // ========================================================
   // Register map
   // ========================================================
   typedef enum logic [REG_INDEX_WIDTH-1:0] {
      REG_MODULE_REV = 5'd0,   // RO
      REG_FIFO_CTL   = 5'd1,   // WO clear bits, reads zero
      REG_LOAD_F0    = 5'd2,   // W pushes a word, R returns count
      REG_LOAD_F1    = 5'd3,
      REG_START      = 5'd4    // W selects on-deck FIFO, R returns active
   } reg_index_e;

   // Clear bits of a REG_FIFO_CTL write
   localparam int BIT_F0_CLEAR = 0;
   localparam int BIT_F1_CLEAR = 1;

   // Response codes
   localparam logic [1:0] RESP_OKAY   = 2'd0;
   localparam logic [1:0] RESP_DECERR = 2'd3;

   // FIFO selection, same encoding as the REG_START value
   typedef enum logic [1:0] {
      SEL_NONE = 2'd0,
      SEL_F0   = 2'd1,
      SEL_F1   = 2'd2
   } fifo_sel_e;

endpackage

`default_nettype wire

//--- rtl/pattern_regs.sv
// Register decode for the pattern streamer
// Write and read strobes are one cycle wide; the response follows one cycle later
// Loads and clears act combinationally on the FIFOs at the write edge
// A load or clear of the active FIFO is refused but still answers OKAY
// Limit: loading or clearing the on-deck FIFO on the very edge where the
// sequencer picks it up is not arbitrated; stop or switch first

`timescale 1ns/1ps
`default_nettype none

module pattern_regs #(
   parameter int PATTERN_WIDTH = pattern_pkg::DEFAULT_PATTERN_WIDTH,
   parameter int FIFO_DEPTH    = pattern_pkg::DEFAULT_FIFO_DEPTH,
   localparam int CNT_W        = $clog2(FIFO_DEPTH + 1)
) (
   input  logic                                     clk,
   input  logic                                     resetn,
   // Register port
   input  logic                                     wr_en,
   input  pattern_pkg::reg_index_e                  wr_index,
   input  logic [pattern_pkg::REG_DATA_WIDTH-1:0]   wr_data,
   output logic                                     wr_done,
   output logic [1:0]                               wr_resp,
   input  logic                                     rd_en,
   input  pattern_pkg::reg_index_e                  rd_index,
   output logic                                     rd_valid,
   output logic [pattern_pkg::REG_DATA_WIDTH-1:0]   rd_data,
   output logic [1:0]                               rd_resp,
   // FIFO status and control
   input  logic [CNT_W-1:0]                         count0,
   input  logic [CNT_W-1:0]                         count1,
   input  pattern_pkg::fifo_sel_e                   active,
   output logic                                     load0,
   output logic                                     load1,
   output logic                                     clear0,
   output logic                                     clear1,
   output logic [PATTERN_WIDTH-1:0]                 load_data,
   output pattern_pkg::fifo_sel_e                   on_deck
);

   localparam int DW = pattern_pkg::REG_DATA_WIDTH;
   localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(FIFO_DEPTH);

   logic f0_busy;
   logic f1_busy;
   logic ctl_write;

   // A FIFO is busy while the sequencer streams from it
   assign f0_busy   = (active == pattern_pkg::SEL_F0);
   assign f1_busy   = (active == pattern_pkg::SEL_F1);
   assign ctl_write = wr_en && (wr_index == pattern_pkg::REG_FIFO_CTL);

   // ========================================================
   // Immediate loads and clears
   // ========================================================
   // Push only into an idle FIFO with room left
   assign load0 = wr_en && (wr_index == pattern_pkg::REG_LOAD_F0) && !f0_busy &&
                  (count0 != FULL_COUNT);
   assign load1 = wr_en && (wr_index == pattern_pkg::REG_LOAD_F1) && !f1_busy &&
                  (count1 != FULL_COUNT);

   // Low bits of the write word form the pattern word
   assign load_data = PATTERN_WIDTH'(wr_data);

   assign clear0 = ctl_write && wr_data[pattern_pkg::BIT_F0_CLEAR] && !f0_busy;
   assign clear1 = ctl_write && wr_data[pattern_pkg::BIT_F1_CLEAR] && !f1_busy;

   // ========================================================
   // Write side
   // ========================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         wr_done <= 1'b0;
         on_deck <= pattern_pkg::SEL_NONE;
      end else begin
         wr_done <= wr_en;
         // Start only an empty-free FIFO; other values are dropped
         if (wr_en && (wr_index == pattern_pkg::REG_START)) begin
            if (wr_data == DW'(0))
               on_deck <= pattern_pkg::SEL_NONE;
            else if (wr_data == DW'(1) && count0 != '0)
               on_deck <= pattern_pkg::SEL_F0;
            else if (wr_data == DW'(2) && count1 != '0)
               on_deck <= pattern_pkg::SEL_F1;
         end
         // An accepted clear of the on-deck FIFO cancels its selection
         if ((clear0 && on_deck == pattern_pkg::SEL_F0) ||
             (clear1 && on_deck == pattern_pkg::SEL_F1))
            on_deck <= pattern_pkg::SEL_NONE;
      end
   end

   // Revision register is read only, so a write to it is a decode error too
   always_ff @(posedge clk) begin
      if (wr_en) begin
         case (wr_index)
            pattern_pkg::REG_FIFO_CTL,
            pattern_pkg::REG_LOAD_F0,
            pattern_pkg::REG_LOAD_F1,
            pattern_pkg::REG_START: wr_resp <= pattern_pkg::RESP_OKAY;
            default:                wr_resp <= pattern_pkg::RESP_DECERR;
         endcase
      end
   end

   // ========================================================
   // Read side
   // ========================================================
   always_ff @(posedge clk) begin
      if (!resetn)
         rd_valid <= 1'b0;
      else
         rd_valid <= rd_en;
   end

   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_resp <= pattern_pkg::RESP_OKAY;
         case (rd_index)
            pattern_pkg::REG_MODULE_REV: rd_data <= pattern_pkg::MODULE_VERSION;
            pattern_pkg::REG_FIFO_CTL:   rd_data <= '0;
            pattern_pkg::REG_LOAD_F0:    rd_data <= DW'(count0);
            pattern_pkg::REG_LOAD_F1:    rd_data <= DW'(count1);
            pattern_pkg::REG_START:      rd_data <= DW'(active);
            default: begin
               rd_data <= '0;
               rd_resp <= pattern_pkg::RESP_DECERR;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

//--- rtl/loop_fifo.sv
// Recirculating pattern FIFO
// A pop moves the head word to the tail, so count is unchanged by it
// Load and pop must not coincide; the register stage refuses loads
// into the active FIFO and loads into a full one
// Clear empties the FIFO in one cycle and wins over load and pop

`timescale 1ns/1ps
`default_nettype none

module loop_fifo #(
   parameter int PATTERN_WIDTH = pattern_pkg::DEFAULT_PATTERN_WIDTH,
   parameter int FIFO_DEPTH    = pattern_pkg::DEFAULT_FIFO_DEPTH,
   localparam int CNT_W        = $clog2(FIFO_DEPTH + 1)
) (
   input  logic                     clk,
   input  logic                     resetn,
   input  logic                     load,
   input  logic [PATTERN_WIDTH-1:0] load_data,
   input  logic                     clear,
   input  logic                     pop,
   output logic [PATTERN_WIDTH-1:0] head,
   output logic [CNT_W-1:0]         count
);

   localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
   localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);

   logic [PATTERN_WIDTH-1:0] mem [FIFO_DEPTH];
   logic [PTR_W-1:0]         rd_ptr;
   logic [PTR_W-1:0]         wr_ptr;
   logic                     do_pop;
   logic                     do_write;
   logic [PATTERN_WIDTH-1:0] wr_word;

   // Pointer step with wrap, depth need not be a power of two
   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      if (ptr == LAST_PTR)
         return '0;
      return ptr + 1'b1;
   endfunction

   assign head = mem[rd_ptr];

   // Popping an empty FIFO is a no-op
   assign do_pop   = pop && (count != '0);
   assign do_write = !clear && (load || do_pop);

   // Tail takes either the new word or the departing head
   assign wr_word = load ? load_data : head;

   // Storage
   always_ff @(posedge clk) begin
      if (do_write)
         mem[wr_ptr] <= wr_word;
   end

   // ========================================================
   // Pointers and occupancy
   // ========================================================
   always_ff @(posedge clk) begin
      if (!resetn || clear) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_write)
            wr_ptr <= next_ptr(wr_ptr);
         if (do_pop)
            rd_ptr <= next_ptr(rd_ptr);
         // Only a load changes occupancy
         if (load)
            count <= count + 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- rtl/stream_sequencer.sv
// Output sequencer of the pattern streamer
// Streams the active FIFO in passes of count words on a valid/ready port
// The on-deck selection is sampled only when idle or on the last transfer
// of a pass, so a switch or stop never cuts a pass short
// out_data holds still while stalled because the FIFO head does not move

`timescale 1ns/1ps
`default_nettype none

module stream_sequencer #(
   parameter int PATTERN_WIDTH = pattern_pkg::DEFAULT_PATTERN_WIDTH,
   parameter int FIFO_DEPTH    = pattern_pkg::DEFAULT_FIFO_DEPTH,
   localparam int CNT_W        = $clog2(FIFO_DEPTH + 1)
) (
   input  logic                     clk,
   input  logic                     resetn,
   input  pattern_pkg::fifo_sel_e   on_deck,
   input  logic [CNT_W-1:0]         count0,
   input  logic [CNT_W-1:0]         count1,
   input  logic [PATTERN_WIDTH-1:0] head0,
   input  logic [PATTERN_WIDTH-1:0] head1,
   input  logic                     out_ready,
   output logic                     out_valid,
   output logic [PATTERN_WIDTH-1:0] out_data,
   output pattern_pkg::fifo_sel_e   active,
   output logic                     pop0,
   output logic                     pop1
);

   typedef enum logic {
      SEQ_IDLE,
      SEQ_STREAM
   } seq_state_e;

   seq_state_e       seq_state;
   logic [CNT_W-1:0] remaining;   // words left in this pass
   logic [CNT_W-1:0] deck_count;
   logic             xfer;
   logic             take_next;

   assign out_valid = (seq_state == SEQ_STREAM);
   assign xfer      = out_valid && out_ready;

   // Selection is re-read at a pass boundary or while idle
   assign take_next  = (seq_state == SEQ_IDLE) || (xfer && remaining == CNT_W'(1));
   assign deck_count = (on_deck == pattern_pkg::SEL_F1) ? count1 : count0;

   // Head of the active FIFO drives the stream
   always_comb begin
      case (active)
         pattern_pkg::SEL_F0: out_data = head0;
         pattern_pkg::SEL_F1: out_data = head1;
         default:             out_data = '0;
      endcase
   end

   // Each transfer recirculates one word in the active FIFO
   assign pop0 = xfer && (active == pattern_pkg::SEL_F0);
   assign pop1 = xfer && (active == pattern_pkg::SEL_F1);

   // ========================================================
   // Pass control
   // ========================================================
   always_ff @(posedge clk) begin
      if (!resetn) begin
         seq_state <= SEQ_IDLE;
         active    <= pattern_pkg::SEL_NONE;
         remaining <= '0;
      end else if (take_next) begin
         if (on_deck == pattern_pkg::SEL_NONE) begin
            // Stop after the pass that just ended
            seq_state <= SEQ_IDLE;
            active    <= pattern_pkg::SEL_NONE;
         end else begin
            // Same or other FIFO, no gap between passes
            seq_state <= SEQ_STREAM;
            active    <= on_deck;
            remaining <= deck_count;
         end
      end else if (xfer) begin
         remaining <= remaining - 1'b1;
      end
   end

endmodule

`default_nettype wire

//--- rtl/pattern_streamer.sv
// Looping pattern streamer top level
// Two recirculating FIFOs are loaded through a simple register port
// and one of them at a time is streamed out in a continuous loop
// FIFO_DEPTH sets each FIFO's capacity and the count readback width

`timescale 1ns/1ps
`default_nettype none

module pattern_streamer #(
   parameter int PATTERN_WIDTH = pattern_pkg::DEFAULT_PATTERN_WIDTH,
   parameter int FIFO_DEPTH    = pattern_pkg::DEFAULT_FIFO_DEPTH
) (
   input  logic                                   clk,
   input  logic                                   resetn,
   // Register port
   input  logic                                   wr_en,
   input  pattern_pkg::reg_index_e                wr_index,
   input  logic [pattern_pkg::REG_DATA_WIDTH-1:0] wr_data,
   output logic                                   wr_done,
   output logic [1:0]                             wr_resp,
   input  logic                                   rd_en,
   input  pattern_pkg::reg_index_e                rd_index,
   output logic                                   rd_valid,
   output logic [pattern_pkg::REG_DATA_WIDTH-1:0] rd_data,
   output logic [1:0]                             rd_resp,
   // Output stream
   output logic [PATTERN_WIDTH-1:0]               out_data,
   output logic                                   out_valid,
   input  logic                                   out_ready
);

   localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

   logic                     load0;
   logic                     load1;
   logic                     clear0;
   logic                     clear1;
   logic [PATTERN_WIDTH-1:0] load_data;
   logic [CNT_W-1:0]         count0;
   logic [CNT_W-1:0]         count1;
   logic [PATTERN_WIDTH-1:0] head0;
   logic [PATTERN_WIDTH-1:0] head1;
   logic                     pop0;
   logic                     pop1;
   pattern_pkg::fifo_sel_e   on_deck;
   pattern_pkg::fifo_sel_e   active;

   // ========================================================
   // Register decode
   // ========================================================
   pattern_regs #(
      .PATTERN_WIDTH (PATTERN_WIDTH),
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) regs (
      .clk       (clk),
      .resetn    (resetn),
      .wr_en     (wr_en),
      .wr_index  (wr_index),
      .wr_data   (wr_data),
      .wr_done   (wr_done),
      .wr_resp   (wr_resp),
      .rd_en     (rd_en),
      .rd_index  (rd_index),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data),
      .rd_resp   (rd_resp),
      .count0    (count0),
      .count1    (count1),
      .active    (active),
      .load0     (load0),
      .load1     (load1),
      .clear0    (clear0),
      .clear1    (clear1),
      .load_data (load_data),
      .on_deck   (on_deck)
   );

   // ========================================================
   // Pattern store
   // ========================================================
   loop_fifo #(
      .PATTERN_WIDTH (PATTERN_WIDTH),
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) fifo_0 (
      .clk       (clk),
      .resetn    (resetn),
      .load      (load0),
      .load_data (load_data),
      .clear     (clear0),
      .pop       (pop0),
      .head      (head0),
      .count     (count0)
   );

   loop_fifo #(
      .PATTERN_WIDTH (PATTERN_WIDTH),
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) fifo_1 (
      .clk       (clk),
      .resetn    (resetn),
      .load      (load1),
      .load_data (load_data),
      .clear     (clear1),
      .pop       (pop1),
      .head      (head1),
      .count     (count1)
   );

   // ========================================================
   // Output sequencer
   // ========================================================
   stream_sequencer #(
      .PATTERN_WIDTH (PATTERN_WIDTH),
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) sequencer (
      .clk       (clk),
      .resetn    (resetn),
      .on_deck   (on_deck),
      .count0    (count0),
      .count1    (count1),
      .head0     (head0),
      .head1     (head1),
      .out_ready (out_ready),
      .out_valid (out_valid),
      .out_data  (out_data),
      .active    (active),
      .pop0      (pop0),
      .pop1      (pop1)
   );

endmodule

`default_nettype wire

//--- verification/pattern_streamer_props.sv
// Protocol properties bound into the pattern streamer top level
// Covers output hold under back-pressure and the one-cycle register responses
// Checks are disabled while resetn is low, except the reset check itself

`timescale 1ns/1ps
`default_nettype none

module pattern_streamer_props #(
   parameter int PATTERN_WIDTH = pattern_pkg::DEFAULT_PATTERN_WIDTH
) (
   input logic                     clk,
   input logic                     resetn,
   input logic                     wr_en,
   input logic                     wr_done,
   input logic                     rd_en,
   input logic                     rd_valid,
   input logic [PATTERN_WIDTH-1:0] out_data,
   input logic                     out_valid,
   input logic                     out_ready
);

   // ========================================================
   // Output stream
   // ========================================================
   // Stream stays quiet once reset has been seen
   reset_quiet: assert property (@(posedge clk) $past(!resetn) |-> !out_valid)
      else $error("out_valid high during reset");

   // Stalled word keeps its value and valid stays up
   stall_hold: assert property (@(posedge clk) disable iff (!resetn)
      $past(out_valid && !out_ready) |-> (out_valid && out_data == $past(out_data)))
      else $error("out_data or out_valid changed while stalled");

   // ========================================================
   // Register port timing
   // ========================================================
   rd_latency: assert property (@(posedge clk) disable iff (!resetn)
      rd_valid == $past(rd_en))
      else $error("rd_valid does not follow rd_en by one cycle");

   wr_latency: assert property (@(posedge clk) disable iff (!resetn)
      wr_done == $past(wr_en))
      else $error("wr_done does not follow wr_en by one cycle");

endmodule

bind pattern_streamer pattern_streamer_props #(
   .PATTERN_WIDTH (PATTERN_WIDTH)
) props (
   .clk       (clk),
   .resetn    (resetn),
   .wr_en     (wr_en),
   .wr_done   (wr_done),
   .rd_en     (rd_en),
   .rd_valid  (rd_valid),
   .out_data  (out_data),
   .out_valid (out_valid),
   .out_ready (out_ready)
);

`default_nettype wire

//--- verification/tb_pattern_streamer.sv
// Testbench for the looping pattern streamer
// A queue model of both FIFOs and of the on-deck and active rules predicts
// every output word, read value and response; concurrent assertions compare
// out_ready is random with a fixed seed, so each run repeats exactly
// The first failed check ends the run

`timescale 1ns/1ps
`default_nettype none

module tb_pattern_streamer;

   localparam int PATTERN_WIDTH = pattern_pkg::DEFAULT_PATTERN_WIDTH;
   localparam int FIFO_DEPTH    = pattern_pkg::DEFAULT_FIFO_DEPTH;
   // The sequence takes about 120 cycles at 75 percent ready
   localparam int MAX_CYCLES    = 4000;

   logic                     clk;
   logic                     resetn;
   logic                     wr_en;
   pattern_pkg::reg_index_e  wr_index;
   logic [31:0]              wr_data;
   logic                     wr_done;
   logic [1:0]               wr_resp;
   logic                     rd_en;
   pattern_pkg::reg_index_e  rd_index;
   logic                     rd_valid;
   logic [31:0]              rd_data;
   logic [1:0]               rd_resp;
   logic [PATTERN_WIDTH-1:0] out_data;
   logic                     out_valid;
   logic                     out_ready = 1'b0;
   integer                   seed = 82;
   int                       cycles = 0;

   // Reference model state
   logic [PATTERN_WIDTH-1:0] q0[$];
   logic [PATTERN_WIDTH-1:0] q1[$];
   logic [PATTERN_WIDTH-1:0] word;
   pattern_pkg::fifo_sel_e   m_active;
   pattern_pkg::fifo_sel_e   m_deck;
   pattern_pkg::fifo_sel_e   prev_active;
   int                       m_remaining;
   int                       transfers;
   logic                     exp_valid;
   logic [PATTERN_WIDTH-1:0] exp_head;
   logic [31:0]              exp_rd_data;
   logic [1:0]               exp_rd_resp;
   logic [1:0]               exp_wr_resp;

   pattern_streamer #(
      .PATTERN_WIDTH (PATTERN_WIDTH),
      .FIFO_DEPTH    (FIFO_DEPTH)
   ) uut (
      .clk       (clk),
      .resetn    (resetn),
      .wr_en     (wr_en),
      .wr_index  (wr_index),
      .wr_data   (wr_data),
      .wr_done   (wr_done),
      .wr_resp   (wr_resp),
      .rd_en     (rd_en),
      .rd_index  (rd_index),
      .rd_valid  (rd_valid),
      .rd_data   (rd_data),
      .rd_resp   (rd_resp),
      .out_data  (out_data),
      .out_valid (out_valid),
      .out_ready (out_ready)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   task automatic fail_now(input string msg);
      $display("%s", msg);
      $display("Regression failed");
      $fatal(1);
   endtask

   // Sink accepts about three words in four
   always @(posedge clk) begin
      #2;
      out_ready = (($random(seed) & 3) != 0);
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= MAX_CYCLES)
         fail_now("Timeout, the test sequence did not finish within the cycle limit");
   end

   // ========================================================
   // Reference model, updated at each clock edge
   // ========================================================
   always @(posedge clk) begin
      if (!resetn) begin
         q0.delete();
         q1.delete();
         m_active    = pattern_pkg::SEL_NONE;
         m_deck      = pattern_pkg::SEL_NONE;
         m_remaining = 0;
         transfers   = 0;
      end else begin
         prev_active = m_active;
         // Reads see the state before this edge
         if (rd_en) begin
            exp_rd_resp = pattern_pkg::RESP_OKAY;
            case (rd_index)
               pattern_pkg::REG_MODULE_REV: exp_rd_data = 32'd1;
               pattern_pkg::REG_FIFO_CTL:   exp_rd_data = 32'd0;
               pattern_pkg::REG_LOAD_F0:    exp_rd_data = 32'(q0.size());
               pattern_pkg::REG_LOAD_F1:    exp_rd_data = 32'(q1.size());
               pattern_pkg::REG_START:      exp_rd_data = 32'(m_active);
               default: begin
                  exp_rd_data = 32'd0;
                  exp_rd_resp = pattern_pkg::RESP_DECERR;
               end
            endcase
         end
         // Sequencer: a transfer rotates the active FIFO by one word
         if (m_active != pattern_pkg::SEL_NONE && out_ready) begin
            if (m_active == pattern_pkg::SEL_F0) begin
               word = q0.pop_front();
               q0.push_back(word);
            end else begin
               word = q1.pop_front();
               q1.push_back(word);
            end
            transfers = transfers + 1;
            m_remaining = m_remaining - 1;
         end
         // Pass boundary or idle picks up the on-deck choice
         if (prev_active == pattern_pkg::SEL_NONE || m_remaining == 0) begin
            m_active    = m_deck;
            m_remaining = (m_deck == pattern_pkg::SEL_F1) ? q1.size() : q0.size();
         end
         // Register writes, refusals judged on the active FIFO before the edge
         if (wr_en) begin
            exp_wr_resp = pattern_pkg::RESP_OKAY;
            case (wr_index)
               pattern_pkg::REG_LOAD_F0:
                  if (prev_active != pattern_pkg::SEL_F0 && q0.size() < FIFO_DEPTH)
                     q0.push_back(PATTERN_WIDTH'(wr_data));
               pattern_pkg::REG_LOAD_F1:
                  if (prev_active != pattern_pkg::SEL_F1 && q1.size() < FIFO_DEPTH)
                     q1.push_back(PATTERN_WIDTH'(wr_data));
               pattern_pkg::REG_FIFO_CTL: begin
                  if (wr_data[0] && prev_active != pattern_pkg::SEL_F0) begin
                     q0.delete();
                     if (m_deck == pattern_pkg::SEL_F0)
                        m_deck = pattern_pkg::SEL_NONE;
                  end
                  if (wr_data[1] && prev_active != pattern_pkg::SEL_F1) begin
                     q1.delete();
                     if (m_deck == pattern_pkg::SEL_F1)
                        m_deck = pattern_pkg::SEL_NONE;
                  end
               end
               pattern_pkg::REG_START:
                  if (wr_data == 32'd0)
                     m_deck = pattern_pkg::SEL_NONE;
                  else if (wr_data == 32'd1 && q0.size() != 0)
                     m_deck = pattern_pkg::SEL_F0;
                  else if (wr_data == 32'd2 && q1.size() != 0)
                     m_deck = pattern_pkg::SEL_F1;
               // Revision is read only
               default: exp_wr_resp = pattern_pkg::RESP_DECERR;
            endcase
         end
      end
      exp_valid = (m_active != pattern_pkg::SEL_NONE);
      if (m_active == pattern_pkg::SEL_F0 && q0.size() != 0)
         exp_head = q0[0];
      else if (m_active == pattern_pkg::SEL_F1 && q1.size() != 0)
         exp_head = q1[0];
      else
         exp_head = '0;
   end

   // ========================================================
   // Checks against the model
   // ========================================================
   check_valid: assert property (@(posedge clk) disable iff (!resetn)
      out_valid == exp_valid)
      else fail_now($sformatf("CHECK FAILED out_valid exp=%h got=%h",
                              $sampled(exp_valid), $sampled(out_valid)));

   check_out_data: assert property (@(posedge clk) disable iff (!resetn)
      (out_valid && out_ready) |-> out_data == exp_head)
      else fail_now($sformatf("CHECK FAILED out_data exp=%h got=%h",
                              $sampled(exp_head), $sampled(out_data)));

   check_rd_data: assert property (@(posedge clk) disable iff (!resetn)
      rd_valid |-> (rd_data == exp_rd_data && rd_resp == exp_rd_resp))
      else fail_now($sformatf("CHECK FAILED rd_data/rd_resp exp=%h/%h got=%h/%h",
                              $sampled(exp_rd_data), $sampled(exp_rd_resp),
                              $sampled(rd_data), $sampled(rd_resp)));

   check_wr_resp: assert property (@(posedge clk) disable iff (!resetn)
      wr_done |-> wr_resp == exp_wr_resp)
      else fail_now($sformatf("CHECK FAILED wr_resp exp=%h got=%h",
                              $sampled(exp_wr_resp), $sampled(wr_resp)));

   // ========================================================
   // Register port and wait helpers, entered 2 ns after an edge
   // ========================================================
   task automatic write_reg(input pattern_pkg::reg_index_e idx, input logic [31:0] data);
      wr_en    = 1'b1;
      wr_index = idx;
      wr_data  = data;
      @(posedge clk);
      #2;
      wr_en = 1'b0;
      while (!wr_done) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic read_reg(input pattern_pkg::reg_index_e idx);
      rd_en    = 1'b1;
      rd_index = idx;
      @(posedge clk);
      #2;
      rd_en = 1'b0;
      while (!rd_valid) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic wait_transfers(input int n);
      int target;
      target = transfers + n;
      while (transfers < target) begin
         @(posedge clk);
         #2;
      end
   endtask

   task automatic wait_active(input pattern_pkg::fifo_sel_e sel);
      while (m_active != sel) begin
         @(posedge clk);
         #2;
      end
   endtask

   // ========================================================
   // Stimulus
   // ========================================================
   initial begin
      resetn   = 1'b0;
      wr_en    = 1'b0;
      wr_index = pattern_pkg::REG_MODULE_REV;
      wr_data  = 32'd0;
      rd_en    = 1'b0;
      rd_index = pattern_pkg::REG_MODULE_REV;
      repeat (8) @(posedge clk);
      #2;
      resetn = 1'b1;

      // Revision and decode errors
      read_reg(pattern_pkg::REG_MODULE_REV);
      read_reg(pattern_pkg::reg_index_e'(5'd9));
      write_reg(pattern_pkg::reg_index_e'(5'd9), 32'h1234_5678);

      // Loads, counts, then fill FIFO 1 past full and reload it
      for (int i = 0; i < 5; i++)
         write_reg(pattern_pkg::REG_LOAD_F0, 32'hC0DE_0000 + 32'(i));
      for (int i = 0; i < 3; i++)
         write_reg(pattern_pkg::REG_LOAD_F1, 32'hF1F1_0000 + 32'(i));
      read_reg(pattern_pkg::REG_LOAD_F0);
      read_reg(pattern_pkg::REG_LOAD_F1);
      for (int i = 3; i <= FIFO_DEPTH; i++)
         write_reg(pattern_pkg::REG_LOAD_F1, 32'h0000_1000 + 32'(i));
      read_reg(pattern_pkg::REG_LOAD_F1);
      write_reg(pattern_pkg::REG_FIFO_CTL, 32'd2);
      for (int i = 0; i < 3; i++)
         write_reg(pattern_pkg::REG_LOAD_F1, 32'hF1F1_0000 + 32'(i));
      read_reg(pattern_pkg::REG_LOAD_F1);

      // Three passes of FIFO 0 under back-pressure
      write_reg(pattern_pkg::REG_START, 32'd1);
      // Active follows on-deck one cycle later
      wait_active(pattern_pkg::SEL_F0);
      read_reg(pattern_pkg::REG_START);
      wait_transfers(15);

      // Switch requested mid-pass
      wait_transfers(2);
      write_reg(pattern_pkg::REG_START, 32'd2);
      wait_active(pattern_pkg::SEL_F1);
      wait_transfers(6);

      // Refusals while FIFO 1 streams
      write_reg(pattern_pkg::REG_LOAD_F1, 32'hDEAD_BEEF);
      write_reg(pattern_pkg::REG_FIFO_CTL, 32'd2);
      read_reg(pattern_pkg::REG_LOAD_F1);
      write_reg(pattern_pkg::REG_FIFO_CTL, 32'd1);
      read_reg(pattern_pkg::REG_LOAD_F0);
      write_reg(pattern_pkg::REG_START, 32'd1);
      wait_transfers(4);
      read_reg(pattern_pkg::REG_START);

      // Stop at the end of the pass, then stay idle
      write_reg(pattern_pkg::REG_START, 32'd0);
      wait_active(pattern_pkg::SEL_NONE);
      repeat (10) @(posedge clk);
      #2;
      read_reg(pattern_pkg::REG_START);

      $display("Regression passed");
      $finish;
   end

endmodule

`default_nettype wire

//--- flist.f
rtl/pattern_pkg.sv
rtl/pattern_regs.sv
rtl/loop_fifo.sv
rtl/stream_sequencer.sv
rtl/pattern_streamer.sv
verification/pattern_streamer_props.sv
verification/tb_pattern_streamer.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the pattern streamer testbench with Verilator and runs it
# The result comes from the pass message in the simulation output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_pattern_streamer \
   -f flist.f \
   -o tb_pattern_streamer
build_status=$?
if [ $build_status -ne 0 ]; then
   echo "Verilator build failed with status $build_status"
   exit 1
fi

sim_out=$(./obj_dir/tb_pattern_streamer 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
   echo "Simulation exited with status $sim_status"
   exit 1
fi

if echo "$sim_out" | grep -qx "Regression passed"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1
